// ==== common/lsu_pkg.sv ====
package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Instruction word
  localparam int ILEN           = 32;

  // Exception vector carried down the pipeline
  localparam int EXCEPTION_SIZE = 16;

  ////////////////////////////////////////////////////////////
  // Major opcodes, instruction bits 6:2
  ////////////////////////////////////////////////////////////

  // Loads, I-type
  localparam logic [4:0] OPC_LOAD  = 5'b00000;

  // Stores, S-type
  localparam logic [4:0] OPC_STORE = 5'b01000;

  ////////////////////////////////////////////////////////////
  // Access size codes, func3 field
  ////////////////////////////////////////////////////////////

  // Signed byte, also SB
  localparam logic [2:0] F3_B  = 3'b000;

  // Signed half, also SH
  localparam logic [2:0] F3_H  = 3'b001;

  // Word, also SW
  localparam logic [2:0] F3_W  = 3'b010;

  // Unsigned byte
  localparam logic [2:0] F3_BU = 3'b100;

  // Unsigned half
  localparam logic [2:0] F3_HU = 3'b101;

  ////////////////////////////////////////////////////////////
  // Per-request info, request side to load return side
  ////////////////////////////////////////////////////////////

  // Sent alongside each memory request
  // Offset is the byte position within a 32-bit word
  typedef struct packed {
    logic       is_load;
    logic [2:0] func3;
    logic [1:0] offset;
  } lsu_load_info_t;

endpackage : lsu_pkg

// ==== common/dmem_if.sv ====
interface dmem_if #(
  parameter int XLEN = 32
);

  // Request side, one-cycle strobe
  logic [XLEN  -1:0] adr;
  logic [XLEN  -1:0] d;
  logic              req;
  logic              we;
  logic [XLEN/8-1:0] be;

  // Response side, ack one cycle after req
  logic              ack;
  logic [XLEN  -1:0] q;

  // Request issuer
  modport master (
    output adr, d, req, we, be
  );

  // Memory
  modport slave (
    input  adr, d, req, we, be,
    output ack, q
  );

  // Load return watches the bus only
  modport monitor (
    input adr, req, ack, q
  );

endinterface : dmem_if

// ==== lsu/lsu_req.sv ====
module lsu_req
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  logic                      clk,
  input  logic                      rstn,

  // Pipeline control
  input  logic                      ex_stall,
  input  logic                      id_bubble,
  input  logic                      pipe_flush,

  // Decoded instruction from ID
  input  logic [ILEN          -1:0] id_instr,
  input  logic [EXCEPTION_SIZE-1:0] id_exception,

  // Operands
  input  logic [XLEN          -1:0] opa,
  input  logic [XLEN          -1:0] opb,

  // Towards the rest of the pipeline
  output logic                      lsu_bubble,
  output logic [EXCEPTION_SIZE-1:0] lsu_exception,

  // Towards the load return block
  output lsu_load_info_t            load_info,

  // Data memory bus
  dmem_if.master                    dmem
);

  ////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////

  logic [       4:0] opcode;
  logic [       2:0] func3;
  logic [XLEN  -1:0] imm_s;

  logic              is_load;
  logic              is_store;
  logic              accept;

  // Request fields before the register
  logic [XLEN  -1:0] adr;
  logic [XLEN  -1:0] d;
  logic [XLEN/8-1:0] be;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign opcode   = id_instr[6:2];
  assign func3    = id_instr[14:12];

  // S-type immediate, sign extended
  assign imm_s    = XLEN'($signed({id_instr[31:25], id_instr[11:7]}));

  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);

  // Issue only a live memory op with a clean exception state
  assign accept   = !ex_stall && !id_bubble && !pipe_flush &&
                    !(|id_exception) && (is_load || is_store);

  // Loads use opb, which already carries the I immediate
  assign adr      = is_store ? opa + imm_s : opa + opb;

  ////////////////////////////////////////////////////////////
  // Byte enables and store data
  ////////////////////////////////////////////////////////////

  generate
    if (XLEN == 64)
    begin : g_rv64
      // Eight byte lanes, offset from adr[2:0]
      always_comb
        case (func3)
          F3_B, F3_BU: be = 8'h01 << adr[2:0];
          F3_H, F3_HU: be = 8'h03 << adr[2:0];
          default    : be = 8'h0f << adr[2:0];
        endcase

      always_comb
        case (func3)
          F3_B   : d = {{XLEN- 8{1'b0}}, opb[ 7:0]} << {adr[2:0], 3'b000};
          F3_H   : d = {{XLEN-16{1'b0}}, opb[15:0]} << {adr[2:0], 3'b000};
          default: d = {{XLEN-32{1'b0}}, opb[31:0]} << {adr[2:0], 3'b000};
        endcase
    end
    else
    begin : g_rv32
      // Four byte lanes, word accesses always full width
      always_comb
        case (func3)
          F3_B, F3_BU: be = 4'h1 << adr[1:0];
          F3_H, F3_HU: be = 4'h3 << adr[1:0];
          default    : be = 4'hf;
        endcase

      always_comb
        case (func3)
          F3_B   : d = {{XLEN- 8{1'b0}}, opb[ 7:0]} << {adr[1:0], 3'b000};
          F3_H   : d = {{XLEN-16{1'b0}}, opb[15:0]} << {adr[1:0], 3'b000};
          default: d = opb;
        endcase
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Request strobe and bubble
  ////////////////////////////////////////////////////////////

  // Strobe high for one cycle per accepted op
  // Bubble frozen while EX is stalled
  always_ff @(posedge clk, negedge rstn)
    if (!rstn)
    begin
      dmem.req   <= 1'b0;
      lsu_bubble <= 1'b1;
    end
    else
    begin
      dmem.req <= accept;
      if (!ex_stall)
        lsu_bubble <= !accept;
    end

  // Payload, only loaded on accept
  always_ff @(posedge clk)
    if (accept)
    begin
      dmem.adr          <= adr;
      dmem.we           <= is_store;
      dmem.be           <= be;
      dmem.d            <= d;
      load_info.is_load <= is_load;
      load_info.func3   <= func3;
      load_info.offset  <= adr[1:0];
    end

  ////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////

  // Follows ID one stage later, held during a stall
  always_ff @(posedge clk, negedge rstn)
    if (!rstn)
      lsu_exception <= '0;
    else if (!ex_stall)
      lsu_exception <= id_exception;

endmodule : lsu_req

// ==== lsu/lsu_load_align.sv ====
module lsu_load_align
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
)
(
  input  logic             clk,
  input  logic             rstn,

  // Info for the request on the bus
  input  lsu_load_info_t   load_info,
  dmem_if.monitor          dmem,

  // Formatted load result
  output logic [XLEN-1:0]  lsu_r,
  output logic             lsu_r_valid
);

  ////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////

  lsu_load_info_t  info_q;
  logic [     2:0] byte_sel;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] result;

  // Info of the request now waiting for its ack
  always_ff @(posedge clk, negedge rstn)
    if (!rstn)
      info_q <= '0;
    else if (dmem.req)
      info_q <= load_info;

  // Byte lane of the returned data
  generate
    if (XLEN == 64)
    begin : g_rv64
      logic word_hi;

      // Upper or lower 32-bit half of the doubleword
      always_ff @(posedge clk)
        if (dmem.req)
          word_hi <= dmem.adr[2];

      assign byte_sel = {word_hi, info_q.offset};
    end
    else
    begin : g_rv32
      assign byte_sel = {1'b0, info_q.offset};
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Format
  ////////////////////////////////////////////////////////////

  // Addressed byte down to lane 0
  assign shifted = dmem.q >> {byte_sel, 3'b000};

  always_comb
    case (info_q.func3)
      F3_B   : result = XLEN'($signed(shifted[7:0]));
      F3_BU  : result = XLEN'(shifted[7:0]);
      F3_H   : result = XLEN'($signed(shifted[15:0]));
      F3_HU  : result = XLEN'(shifted[15:0]);
      default: result = XLEN'($signed(shifted[31:0]));
    endcase

  // One pulse per load ack, store acks dropped
  always_ff @(posedge clk, negedge rstn)
    if (!rstn)
      lsu_r_valid <= 1'b0;
    else
      lsu_r_valid <= dmem.ack && info_q.is_load;

  always_ff @(posedge clk)
    if (dmem.ack && info_q.is_load)
      lsu_r <= result;

endmodule : lsu_load_align

// ==== logic/dmem_sram.sv ====
module dmem_sram #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
)
(
  input  logic clk,
  input  logic rstn,

  // Data memory bus
  dmem_if.slave dmem
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Byte offset bits below the word index
  localparam int OFFS_W = $clog2(XLEN/8);
  localparam int IDX_W  = $clog2(MEM_WORDS);

  logic [XLEN -1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  // Word index above the byte offset, upper bits ignored
  assign idx = dmem.adr[OFFS_W +: IDX_W];

  // Byte lane writes on the request edge
  always_ff @(posedge clk)
    if (dmem.req && dmem.we)
    begin
      for (int i = 0; i < XLEN/8; i++)
      begin
        if (dmem.be[i])
          mem[idx][8*i +: 8] <= dmem.d[8*i +: 8];
      end
    end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  // Ack one cycle after every request
  always_ff @(posedge clk, negedge rstn)
    if (!rstn)
      dmem.ack <= 1'b0;
    else
      dmem.ack <= dmem.req;

  // Read word for loads, stores leave q alone
  always_ff @(posedge clk)
    if (dmem.req && !dmem.we)
      dmem.q <= mem[idx];

endmodule : dmem_sram

// ==== logic/lsu_top.sv ====
module lsu_top
  import lsu_pkg::*;
#(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
)
(
  input  logic                      clk,
  input  logic                      rstn,

  // Pipeline control
  input  logic                      ex_stall,
  input  logic                      id_bubble,
  input  logic                      pipe_flush,

  // Instruction and operands from ID
  input  logic [ILEN          -1:0] id_instr,
  input  logic [EXCEPTION_SIZE-1:0] id_exception,
  input  logic [XLEN          -1:0] opa,
  input  logic [XLEN          -1:0] opb,

  // Results
  output logic                      lsu_bubble,
  output logic [EXCEPTION_SIZE-1:0] lsu_exception,
  output logic [XLEN          -1:0] lsu_r,
  output logic                      lsu_r_valid
);

  // Bus between request, memory and load return
  dmem_if #(.XLEN(XLEN)) dmem_bus ();

  // Size and offset of the request on the bus
  lsu_load_info_t load_info;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  lsu_req #(
    .XLEN          (XLEN)
  ) u_lsu_req (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .pipe_flush    (pipe_flush),
    .id_instr      (id_instr),
    .id_exception  (id_exception),
    .opa           (opa),
    .opb           (opb),
    .lsu_bubble    (lsu_bubble),
    .lsu_exception (lsu_exception),
    .load_info     (load_info),
    .dmem          (dmem_bus.master)
  );

  // Memory model
  dmem_sram #(
    .XLEN      (XLEN),
    .MEM_WORDS (MEM_WORDS)
  ) u_dmem_sram (
    .clk       (clk),
    .rstn      (rstn),
    .dmem      (dmem_bus.slave)
  );

  ////////////////////////////////////////////////////////////
  // Load return
  ////////////////////////////////////////////////////////////

  lsu_load_align #(
    .XLEN        (XLEN)
  ) u_lsu_load_align (
    .clk         (clk),
    .rstn        (rstn),
    .load_info   (load_info),
    .dmem        (dmem_bus.monitor),
    .lsu_r       (lsu_r),
    .lsu_r_valid (lsu_r_valid)
  );

endmodule : lsu_top

// ==== bench/lsu_sva.sv ====
module lsu_sva #(
  parameter int XLEN      = 32,
  parameter bit CHECK_ACK = 1'b1
)
(
  input logic            clk,
  input logic            rstn,
  input logic            ex_stall,
  input logic            req,
  input logic            ack,
  input logic [XLEN-1:0] adr
);

  ////////////////////////////////////////////////////////////
  // Request address
  ////////////////////////////////////////////////////////////

  a_adr_known: assert property (@(posedge clk) disable iff (!rstn)
    req |-> !$isunknown(adr))
  else $error("adr unknown while req high");

  ////////////////////////////////////////////////////////////
  // Stall and response timing
  ////////////////////////////////////////////////////////////

  // Request side checks the stall rule and response side the ack timing
  generate
    if (CHECK_ACK)
    begin : g_ack
      // Memory answers each strobe one cycle later and never on its own
      a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
        req |=> ack)
      else $error("no ack one cycle after req");

      a_ack_has_req: assert property (@(posedge clk) disable iff (!rstn)
        ack |-> $past(req))
      else $error("ack without req in the previous cycle");
    end
    else
    begin : g_stall
      // Nothing leaves the request stage after a stalled edge
      a_stall_no_req: assert property (@(posedge clk) disable iff (!rstn)
        ex_stall |=> !req)
      else $error("req issued after a stalled edge");
    end
  endgenerate

endmodule : lsu_sva

// Stall side on the request block
bind lsu_req lsu_sva #(.XLEN(XLEN), .CHECK_ACK(1'b0)) u_lsu_req_sva (
  .clk(clk), .rstn(rstn), .ex_stall(ex_stall),
  .req(dmem.req), .ack(1'b0), .adr(dmem.adr)
);

// Response side on the load return block
bind lsu_load_align lsu_sva #(.XLEN(XLEN), .CHECK_ACK(1'b1)) u_lsu_load_align_sva (
  .clk(clk), .rstn(rstn), .ex_stall(1'b0),
  .req(dmem.req), .ack(dmem.ack), .adr(dmem.adr)
);

// ==== bench/lsu_tb.sv ====
module lsu_tb
  import lsu_pkg::*;
();

  localparam int XLEN      = 32;
  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 2000;

  // Idle slot and a register ALU op
  localparam logic [31:0] NOP     = 32'h0000_0013;
  localparam logic [31:0] ALU_ADD = {7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011};

  logic                      clk = 1'b0;
  logic                      rstn;
  logic                      ex_stall;
  logic                      id_bubble;
  logic                      pipe_flush;
  logic [ILEN          -1:0] id_instr;
  logic [EXCEPTION_SIZE-1:0] id_exception;
  logic [XLEN          -1:0] opa;
  logic [XLEN          -1:0] opb;
  logic                      lsu_bubble;
  logic [EXCEPTION_SIZE-1:0] lsu_exception;
  logic [XLEN          -1:0] lsu_r;
  logic                      lsu_r_valid;

  // Rising edge count, edge N sets cyc to N
  int    cyc = 0;
  int    err_cnt = 0;
  int    check_cnt = 0;
  int    mon_err = 0;
  int    mon_checks = 0;
  string test_name = "reset";

  // Byte image of the data memory
  logic [7:0]  ref_mem [1024];
  logic [31:0] word_adr [16];

  // Loads in flight, oldest first
  logic [31:0] exp_data [$];
  int          exp_due [$];
  string       exp_name [$];

  lsu_top #(
    .XLEN      (XLEN),
    .MEM_WORDS (MEM_WORDS)
  ) u_lsu_top (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .pipe_flush    (pipe_flush),
    .id_instr      (id_instr),
    .id_exception  (id_exception),
    .opa           (opa),
    .opb           (opb),
    .lsu_bubble    (lsu_bubble),
    .lsu_exception (lsu_exception),
    .lsu_r         (lsu_r),
    .lsu_r_valid   (lsu_r_valid)
  );

  always #5 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT)
    begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Encoding and reference model
  ////////////////////////////////////////////////////////////

  // I-type load, rd x1, rs1 x2
  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd2, f3, 5'd1, 7'b0000011};
  endfunction

  // S-type store, rs1 x2, rs2 x3
  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // Low bytes of data land at a, a+1, ...
  function automatic void model_write(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] data);
    int n;
    case (f3)
      F3_B   : n = 1;
      F3_H   : n = 2;
      default: n = 4;
    endcase
    for (int k = 0; k < n; k++)
      ref_mem[10'(a + 32'(k))] = data[8*k +: 8];
  endfunction

  // Little endian gather, then sign or zero extend by size code
  function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] a);
    logic [31:0] w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = ref_mem[10'(a + 32'(k))];
    case (f3)
      F3_B   : return {{24{w[7]}}, w[7:0]};
      F3_BU  : return {24'h0, w[7:0]};
      F3_H   : return {{16{w[15]}}, w[15:0]};
      F3_HU  : return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    check_cnt++;
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // One ID slot, edge_no is the number of the driving edge
  task automatic issue(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
                       input logic [15:0] exc, input logic flush, output int edge_no);
    @(posedge clk);
    // cyc still holds the previous edge here
    edge_no = cyc + 1;
    id_instr     <= instr;
    opa          <= a;
    opb          <= b;
    id_exception <= exc;
    pipe_flush   <= flush;
    id_bubble    <= 1'b0;
  endtask

  task automatic idle();
    @(posedge clk);
    id_instr     <= NOP;
    id_bubble    <= 1'b1;
    id_exception <= '0;
    pipe_flush   <= 1'b0;
  endtask

  task automatic expect_load(input logic [2:0] f3, input logic [31:0] a, input int due);
    exp_name.push_back(test_name);
    exp_data.push_back(load_value(f3, a));
    exp_due.push_back(due);
  endtask

  // Random immediate, base register makes up the rest
  task automatic store_op(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] data,
                          input logic [15:0] exc, input logic flush);
    logic [11:0] imm;
    int          edge_no;
    imm = 12'($urandom);
    issue(enc_s(f3, imm), a - sext12(imm), data, exc, flush, edge_no);
    if (exc == '0 && !flush)
      model_write(f3, a, data);
  endtask

  // opb carries the I immediate for loads
  task automatic load_op(input logic [2:0] f3, input logic [31:0] a);
    logic [11:0] imm;
    int          edge_no;
    imm = 12'($urandom);
    issue(enc_i(f3, imm), a - sext12(imm), sext12(imm), '0, 1'b0, edge_no);
    // Request, ack, then result register
    expect_load(f3, a, edge_no + 3);
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (exp_data.size() != 0 && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    check_cnt++;
    assert (exp_data.size() == 0)
    else
    begin
      err_cnt++;
      $display("%s: %0d load results never came back", test_name, exp_data.size());
    end
  endtask

  // Present an access under stall, then let it go
  task automatic stall_access(input logic [31:0] instr, input logic [31:0] a,
                              input logic [31:0] b, input int hold, output int release_edge);
    @(posedge clk);
    id_instr     <= instr;
    opa          <= a;
    opb          <= b;
    id_bubble    <= 1'b0;
    id_exception <= '0;
    pipe_flush   <= 1'b0;
    ex_stall     <= 1'b1;
    repeat (hold)
    begin
      @(negedge clk);
      compare_value({test_name, " lsu_bubble"}, 32'd1, {31'h0, lsu_bubble});
    end
    @(posedge clk);
    ex_stall     <= 1'b0;
    release_edge = cyc + 1;
    idle();
  endtask

  ////////////////////////////////////////////////////////////
  // Result monitor
  ////////////////////////////////////////////////////////////

  // Every lsu_r_valid must match the oldest load, on its cycle
  always @(negedge clk)
  begin : result_check
    string       name;
    logic [31:0] data;
    int          due;
    if (rstn && lsu_r_valid)
    begin
      mon_checks++;
      assert (exp_data.size() != 0)
      else
      begin
        mon_err++;
        $display("%s: lsu_r_valid pulsed with no load outstanding", test_name);
      end
      if (exp_data.size() != 0)
      begin
        name = exp_name.pop_front();
        data = exp_data.pop_front();
        due  = exp_due.pop_front();
        mon_checks += 2;
        assert (lsu_r === data)
        else
        begin
          mon_err++;
          $display("error %s: expected %h actual %h", name, data, lsu_r);
        end
        assert (cyc == due)
        else
        begin
          mon_err++;
          $display("error %s: expected cycle %0d actual cycle %0d", name, due, cyc);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic word_round_trip();
    test_name = "word_round_trip";
    for (int i = 0; i < 16; i++)
    begin
      word_adr[i] = ($urandom % MEM_WORDS) * 4;
      store_op(F3_W, word_adr[i], $urandom, '0, 1'b0);
    end
    idle();
    for (int i = 0; i < 16; i++)
    begin
      load_op(F3_W, word_adr[i]);
      idle();
    end
    wait_results();
  endtask

  task automatic sub_word();
    logic [31:0] base;
    logic [31:0] data;
    test_name = "sub_word";
    base = ($urandom % MEM_WORDS) * 4;
    store_op(F3_W, base, $urandom, '0, 1'b0);
    // Sign bit set on odd offsets only
    for (int off = 0; off < 4; off++)
    begin
      data    = $urandom;
      data[7] = off[0];
      store_op(F3_B, base + 32'(off), data, '0, 1'b0);
    end
    for (int off = 0; off < 4; off++)
    begin
      load_op(F3_B, base + 32'(off));
      load_op(F3_BU, base + 32'(off));
    end
    for (int h = 0; h < 2; h++)
    begin
      data     = $urandom;
      data[15] = h[0];
      store_op(F3_H, base + 32'(2 * h), data, '0, 1'b0);
    end
    for (int h = 0; h < 2; h++)
    begin
      load_op(F3_H, base + 32'(2 * h));
      load_op(F3_HU, base + 32'(2 * h));
    end
    load_op(F3_W, base);
    idle();
    wait_results();
  endtask

  task automatic non_memory();
    int edge_no;
    test_name = "non_memory";
    issue(ALU_ADD, word_adr[0], $urandom, '0, 1'b0, edge_no);
    // Load opcode, but marked as a bubble
    @(posedge clk);
    id_instr  <= enc_i(F3_W, 12'h0);
    opa       <= word_adr[0];
    opb       <= '0;
    id_bubble <= 1'b1;
    @(negedge clk);
    compare_value("non_memory alu lsu_bubble", 32'd1, {31'h0, lsu_bubble});
    idle();
    @(negedge clk);
    compare_value("non_memory bubble lsu_bubble", 32'd1, {31'h0, lsu_bubble});
    load_op(F3_W, word_adr[0]);
    idle();
    wait_results();
  endtask

  task automatic exception_flush();
    logic [15:0] exc;
    test_name = "exception_flush";
    exc = 16'($urandom) | 16'h1;
    store_op(F3_W, word_adr[1], $urandom, exc, 1'b0);
    idle();
    @(negedge clk);
    compare_value("exception_flush lsu_exception", {16'h0, exc}, {16'h0, lsu_exception});
    compare_value("exception_flush lsu_bubble", 32'd1, {31'h0, lsu_bubble});
    idle();
    @(negedge clk);
    compare_value("exception_flush clear", 32'd0, {16'h0, lsu_exception});
    store_op(F3_W, word_adr[1], $urandom, '0, 1'b1);
    store_op(F3_B, word_adr[1] + 32'd1, $urandom, '0, 1'b1);
    idle();
    load_op(F3_W, word_adr[1]);
    idle();
    wait_results();
  endtask

  task automatic stall();
    logic [11:0] imm;
    logic [31:0] data;
    int          rel;
    test_name = "stall";
    imm  = 12'($urandom);
    data = $urandom;
    stall_access(enc_s(F3_W, imm), word_adr[2] - sext12(imm), data, 4, rel);
    model_write(F3_W, word_adr[2], data);
    // Single accept after release
    @(negedge clk);
    compare_value("stall release lsu_bubble", 32'd0, {31'h0, lsu_bubble});
    @(negedge clk);
    compare_value("stall after lsu_bubble", 32'd1, {31'h0, lsu_bubble});
    imm = 12'($urandom);
    stall_access(enc_i(F3_W, imm), word_adr[2] - sext12(imm), sext12(imm), 5, rel);
    expect_load(F3_W, word_adr[2], rel + 3);
    wait_results();
  endtask

  task automatic back_to_back();
    test_name = "back_to_back";
    load_op(F3_W, word_adr[3]);
    load_op(F3_B, word_adr[4] + 32'd1);
    load_op(F3_HU, word_adr[5] + 32'd2);
    load_op(F3_W, word_adr[6]);
    load_op(F3_BU, word_adr[7] + 32'd3);
    // Store then load of the same word
    store_op(F3_W, word_adr[8], $urandom, '0, 1'b0);
    load_op(F3_W, word_adr[8]);
    idle();
    wait_results();
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h5b082a2a));
    rstn         = 1'b0;
    ex_stall     = 1'b0;
    id_bubble    = 1'b1;
    pipe_flush   = 1'b0;
    id_instr     = NOP;
    id_exception = '0;
    opa          = '0;
    opb          = '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    compare_value("reset lsu_bubble", 32'd1, {31'h0, lsu_bubble});
    compare_value("reset lsu_exception", 32'd0, {16'h0, lsu_exception});
    compare_value("reset lsu_r_valid", 32'd0, {31'h0, lsu_r_valid});

    word_round_trip();
    sub_word();
    non_memory();
    exception_flush();
    stall();
    back_to_back();
    repeat (5) @(posedge clk);

    $display("%0d checks, %0d errors", check_cnt + mon_checks, err_cnt + mon_err);
    if (err_cnt + mon_err == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule : lsu_tb

// ==== src.f ====
common/lsu_pkg.sv
common/dmem_if.sv
lsu/lsu_req.sv
lsu/lsu_load_align.sv
logic/dmem_sram.sv
logic/lsu_top.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f src.f -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
  exit 0
else
  exit 1
fi
